/* logic/spi_regs_pkg.sv */
/*
 * SPI master register map
 * Bus addresses, control register fields and the control reset value
 */
package spi_regs_pkg;

    // Width of the register bus
    localparam int bus_addr_width = 6;
    localparam int bus_data_width = 32;

    // Register addresses on the bus, one word apart
    typedef enum logic [bus_addr_width-1:0] {
        addr_control = 6'h00,
        addr_trigger = 6'h04,
        addr_status  = 6'h08,
        addr_data_0  = 6'h10,
        addr_data_1  = 6'h14,
        addr_data_2  = 6'h18
    } reg_addr_e;

    // SCLK divider field
    localparam int ctl_divider_lsb = 0;
    localparam int ctl_divider_width = 3;
    // Transfer length field, holds the bit count minus one
    localparam int ctl_length_lsb = 3;
    localparam int ctl_length_width = 5;
    // Single bit mode flags
    localparam int ctl_lsb_first_bit = 8;
    localparam int ctl_ss_polarity_bit = 9;
    localparam int ctl_clock_polarity_bit = 10;

    // Divider 0, one bit, MSB first, SS active low, SCLK idle low
    localparam logic [bus_data_width-1:0] ctl_reset_value = 32'h0000_0000;

endpackage

/* logic/spi_core_pkg.sv */
/*
 * SPI master core definitions
 * Lane count, datapath widths and the transfer engine states
 */
package spi_core_pkg;

    // Number of parallel MOSI/MISO lanes sharing SCLK and SS
    localparam int n_channels = 3;

    // Width of one transmit or receive word
    localparam int word_width = 32;

    // Bit count field, stores length minus one so 1 to 32 bits fit
    localparam int length_width = 5;

    // SCLK divider setting, 8 rates
    localparam int divider_width = 3;

    // Transfer engine states
    // Lead and trail each last one SCLK half period around the shift phase
    typedef enum logic [1:0] {
        state_idle  = 2'd0,
        state_lead  = 2'd1,
        state_shift = 2'd2,
        state_trail = 2'd3
    } engine_state_e;

endpackage

/* logic/spi_sclk_gen.sv */
/*
 * SCLK generator
 * Produces half period ticks from the system clock and drives SCLK
 */
module spi_sclk_gen (
    input  logic clock,
    input  logic reset,
    input  logic enable,
    input  logic toggle,
    input  logic [spi_core_pkg::divider_width-1:0] divider_setting,
    input  logic clock_polarity,
    output logic half_tick,
    output logic sclk
);

    // One extra bit so the count can reach 2 * (divider + 1) - 1
    logic [spi_core_pkg::divider_width:0] tick_count;
    // SCLK relative to its idle level
    logic phase;

    // Terminal count is 2 * divider + 1, a half period of 2 * (divider + 1) cycles
    assign half_tick = enable && (tick_count == {divider_setting, 1'b1});

    always_ff @(posedge clock) begin
        if (!reset) begin
            tick_count <= '0;
            phase <= 1'b0;
        end else if (!enable) begin
            // Restart the half period cleanly for the next transfer
            tick_count <= '0;
            phase <= 1'b0;
        end else begin
            if (half_tick) begin
                tick_count <= '0;
            end else begin
                tick_count <= tick_count + 1'b1;
            end
            if (toggle) begin
                phase <= ~phase;
            end
        end
    end

    // Held at the idle level whenever the generator is off
    assign sclk = clock_polarity ^ (phase & enable);

endmodule

/* logic/spi_reg_decode.sv */
/*
 * SPI register decoder
 * Turns bus strobes into control settings, transmit words and start requests
 */
module spi_reg_decode (
    input  logic clock,
    input  logic reset,
    input  logic bus_write,
    input  logic bus_read,
    input  logic [spi_regs_pkg::bus_addr_width-1:0] bus_address,
    input  logic [spi_regs_pkg::bus_data_width-1:0] bus_write_data,
    input  logic start,
    input  logic busy,
    input  logic [spi_core_pkg::word_width-1:0] rx_words [spi_core_pkg::n_channels],
    output logic [spi_regs_pkg::bus_data_width-1:0] bus_read_data,
    output logic [spi_core_pkg::divider_width-1:0] divider_setting,
    output logic [spi_core_pkg::length_width-1:0] transfer_length,
    output logic lsb_first,
    output logic ss_polarity,
    output logic clock_polarity,
    output logic [spi_core_pkg::word_width-1:0] tx_words [spi_core_pkg::n_channels],
    output logic start_request
);

    logic [spi_regs_pkg::bus_data_width-1:0] control_reg;
    spi_regs_pkg::reg_addr_e address;

    // Bus address seen as a register name
    assign address = spi_regs_pkg::reg_addr_e'(bus_address);

    // Split the control register into its fields
    assign divider_setting =
        control_reg[spi_regs_pkg::ctl_divider_lsb +: spi_regs_pkg::ctl_divider_width];
    assign transfer_length =
        control_reg[spi_regs_pkg::ctl_length_lsb +: spi_regs_pkg::ctl_length_width];
    assign lsb_first = control_reg[spi_regs_pkg::ctl_lsb_first_bit];
    assign ss_polarity = control_reg[spi_regs_pkg::ctl_ss_polarity_bit];
    assign clock_polarity = control_reg[spi_regs_pkg::ctl_clock_polarity_bit];

    // Any write to the trigger register starts a transfer, as does the start pin
    // The engine drops the request while a transfer is running
    assign start_request = (bus_write && address == spi_regs_pkg::addr_trigger) || start;

    always_ff @(posedge clock) begin
        if (!reset) begin
            control_reg <= spi_regs_pkg::ctl_reset_value;
        end else if (bus_write && address == spi_regs_pkg::addr_control) begin
            control_reg <= bus_write_data;
        end
    end

    // Transmit words are written through the data registers
    always_ff @(posedge clock) begin
        if (bus_write) begin
            case (address)
                spi_regs_pkg::addr_data_0: tx_words[0] <= bus_write_data;
                spi_regs_pkg::addr_data_1: tx_words[1] <= bus_write_data;
                spi_regs_pkg::addr_data_2: tx_words[2] <= bus_write_data;
                default: ;
            endcase
        end
    end

    // Read data is registered, so it is valid the cycle after the strobe
    // Data registers read back the received words, not the transmit words
    always_ff @(posedge clock) begin
        if (!reset) begin
            bus_read_data <= '0;
        end else if (bus_read) begin
            case (address)
                spi_regs_pkg::addr_control: bus_read_data <= control_reg;
                spi_regs_pkg::addr_status:  bus_read_data <= {31'b0, busy};
                spi_regs_pkg::addr_data_0:  bus_read_data <= rx_words[0];
                spi_regs_pkg::addr_data_1:  bus_read_data <= rx_words[1];
                spi_regs_pkg::addr_data_2:  bus_read_data <= rx_words[2];
                default:                    bus_read_data <= '0;
            endcase
        end
    end

endmodule

/* logic/spi_transfer_engine.sv */
/*
 * SPI transfer engine
 * Sequences SS, the SCLK edges, the per-lane strobes and the done pulse
 */
module spi_transfer_engine (
    input  logic clock,
    input  logic reset,
    input  logic start_request,
    input  logic [spi_core_pkg::length_width-1:0] transfer_length,
    input  logic [spi_core_pkg::divider_width-1:0] divider_setting,
    input  logic clock_polarity,
    input  logic ss_polarity,
    output logic busy,
    output logic ss,
    output logic sclk,
    output logic load,
    output logic sample,
    output logic shift,
    output logic data_valid
);

    spi_core_pkg::engine_state_e state;
    // Counts SCLK edges in the shift state, up to 2 * 32 - 1
    logic [spi_core_pkg::length_width:0] edge_count;
    logic half_tick;
    logic toggle;
    logic last_edge;

    // SCLK only moves during the shift state
    assign toggle = half_tick && (state == spi_core_pkg::state_shift);

    // Final edge of a transfer of transfer_length + 1 bits
    assign last_edge = (edge_count == {transfer_length, 1'b1});

    // Even counts are leading edges, odd counts trailing edges
    assign sample = toggle && !edge_count[0];
    // No shift on the last edge, the lanes keep their final bit
    assign shift = toggle && edge_count[0] && !last_edge;

    assign busy = (state != spi_core_pkg::state_idle);

    // SS is active whenever busy, at the chosen polarity
    // Polarity 1 gives an active high SS
    assign ss = busy ~^ ss_polarity;

    spi_sclk_gen spi_sclk_gen_i (
        .clock(clock),
        .reset(reset),
        .enable(busy),
        .toggle(toggle),
        .divider_setting(divider_setting),
        .clock_polarity(clock_polarity),
        .half_tick(half_tick),
        .sclk(sclk)
    );

    always_ff @(posedge clock) begin
        if (!reset) begin
            state <= spi_core_pkg::state_idle;
            edge_count <= '0;
            load <= 1'b0;
            data_valid <= 1'b0;
        end else begin
            load <= 1'b0;
            data_valid <= 1'b0;
            case (state)
                spi_core_pkg::state_idle: begin
                    // Requests are only taken here, so a busy core ignores them
                    if (start_request) begin
                        state <= spi_core_pkg::state_lead;
                        edge_count <= '0;
                        load <= 1'b1;
                    end
                end
                spi_core_pkg::state_lead: begin
                    // Gives the lanes half a period to settle their first bit
                    if (half_tick) begin
                        state <= spi_core_pkg::state_shift;
                    end
                end
                spi_core_pkg::state_shift: begin
                    if (half_tick) begin
                        edge_count <= edge_count + 1'b1;
                        if (last_edge) begin
                            state <= spi_core_pkg::state_trail;
                        end
                    end
                end
                spi_core_pkg::state_trail: begin
                    // SS drops together with the done pulse
                    if (half_tick) begin
                        state <= spi_core_pkg::state_idle;
                        data_valid <= 1'b1;
                    end
                end
                default: state <= spi_core_pkg::state_idle;
            endcase
        end
    end

endmodule

/* logic/spi_shift_channel.sv */
/*
 * SPI lane shift register
 * Serializes one transmit word on MOSI and assembles the word seen on MISO
 */
module spi_shift_channel (
    input  logic clock,
    input  logic reset,
    input  logic load,
    input  logic sample,
    input  logic shift,
    input  logic lsb_first,
    input  logic [spi_core_pkg::length_width-1:0] transfer_length,
    input  logic [spi_core_pkg::word_width-1:0] tx_word,
    input  logic miso,
    output logic mosi,
    output logic [spi_core_pkg::word_width-1:0] rx_word
);

    logic [spi_core_pkg::word_width-1:0] tx_reg;
    logic [spi_core_pkg::word_width-1:0] rx_reg;
    logic [spi_core_pkg::word_width-1:0] rx_next;
    // Bit position in flight, shared by the transmit and receive sides
    logic [spi_core_pkg::length_width-1:0] bit_pointer;
    logic final_bit;

    assign mosi = tx_reg[bit_pointer];

    // MSB first walks down to bit 0, LSB first walks up to bit n-1
    assign final_bit = lsb_first ? (bit_pointer == transfer_length) : (bit_pointer == '0);

    // Receive word with the incoming bit merged in at the current position
    always_comb begin
        rx_next = rx_reg;
        rx_next[bit_pointer] = miso;
    end

    always_ff @(posedge clock) begin
        if (!reset) begin
            bit_pointer <= '0;
        end else if (load) begin
            bit_pointer <= lsb_first ? '0 : transfer_length;
        end else if (shift) begin
            if (lsb_first) begin
                bit_pointer <= bit_pointer + 1'b1;
            end else begin
                bit_pointer <= bit_pointer - 1'b1;
            end
        end
    end

    // Bits above the transfer length stay zero because load clears them
    always_ff @(posedge clock) begin
        if (load) begin
            tx_reg <= tx_word;
            rx_reg <= '0;
        end else if (sample) begin
            rx_reg <= rx_next;
        end
    end

    // The visible word only changes once the last bit is in
    always_ff @(posedge clock) begin
        if (!reset) begin
            rx_word <= '0;
        end else if (sample && final_bit) begin
            rx_word <= rx_next;
        end
    end

endmodule

/* logic/spi_master.sv */
/*
 * Multi-lane SPI master
 * Register port, transfer engine and one shift register per lane
 */
module spi_master (
    input  logic clock,
    input  logic reset,
    input  logic bus_write,
    input  logic bus_read,
    input  logic [spi_regs_pkg::bus_addr_width-1:0] bus_address,
    input  logic [spi_regs_pkg::bus_data_width-1:0] bus_write_data,
    input  logic start,
    input  logic [spi_core_pkg::n_channels-1:0] miso,
    output logic [spi_regs_pkg::bus_data_width-1:0] bus_read_data,
    output logic [spi_core_pkg::n_channels-1:0] mosi,
    output logic sclk,
    output logic ss,
    output logic data_valid,
    output logic [spi_core_pkg::word_width-1:0] data_out [spi_core_pkg::n_channels]
);

    logic [spi_core_pkg::divider_width-1:0] divider_setting;
    logic [spi_core_pkg::length_width-1:0] transfer_length;
    logic lsb_first;
    logic ss_polarity;
    logic clock_polarity;
    logic [spi_core_pkg::word_width-1:0] tx_words [spi_core_pkg::n_channels];
    logic start_request;
    logic busy;
    // Lane strobes from the engine
    logic load;
    logic sample;
    logic shift;

    spi_reg_decode spi_reg_decode_i (
        .clock(clock),
        .reset(reset),
        .bus_write(bus_write),
        .bus_read(bus_read),
        .bus_address(bus_address),
        .bus_write_data(bus_write_data),
        .start(start),
        .busy(busy),
        .rx_words(data_out),
        .bus_read_data(bus_read_data),
        .divider_setting(divider_setting),
        .transfer_length(transfer_length),
        .lsb_first(lsb_first),
        .ss_polarity(ss_polarity),
        .clock_polarity(clock_polarity),
        .tx_words(tx_words),
        .start_request(start_request)
    );

    spi_transfer_engine spi_transfer_engine_i (
        .clock(clock),
        .reset(reset),
        .start_request(start_request),
        .transfer_length(transfer_length),
        .divider_setting(divider_setting),
        .clock_polarity(clock_polarity),
        .ss_polarity(ss_polarity),
        .busy(busy),
        .ss(ss),
        .sclk(sclk),
        .load(load),
        .sample(sample),
        .shift(shift),
        .data_valid(data_valid)
    );

    // All lanes run in lock step off the same strobes
    for (genvar i = 0; i < spi_core_pkg::n_channels; i++) begin : g_lane
        spi_shift_channel spi_shift_channel_i (
            .clock(clock),
            .reset(reset),
            .load(load),
            .sample(sample),
            .shift(shift),
            .lsb_first(lsb_first),
            .transfer_length(transfer_length),
            .tx_word(tx_words[i]),
            .miso(miso[i]),
            .mosi(mosi[i]),
            .rx_word(data_out[i])
        );
    end

endmodule

/* test/spi_master_chk.sv */
/*
 * SPI master protocol checker
 * Bound assertions on SS, SCLK and the done pulse
 */
module spi_master_chk (
    input logic clock,
    input logic reset,
    input logic ss,
    input logic sclk,
    input logic data_valid,
    input logic ss_polarity,
    input logic clock_polarity
);

    // SS is inactive whenever it differs from its active level
    logic ss_inactive;
    assign ss_inactive = (ss != ss_polarity);

    // SCLK rests at its idle level outside a transfer
    sclk_idle: assert property (@(posedge clock) disable iff (!reset)
        ss_inactive |-> (sclk == clock_polarity))
        else $error("SCLK left its idle level while SS was inactive");

    // The done pulse is a single cycle
    valid_pulse: assert property (@(posedge clock) disable iff (!reset)
        data_valid |=> !data_valid)
        else $error("data_valid was held for more than one cycle");

    // SS is already released and stays so for the whole done pulse
    ss_released: assert property (@(posedge clock) disable iff (!reset)
        data_valid |-> ss_inactive)
        else $error("SS was active while data_valid was high");

endmodule

bind spi_master spi_master_chk spi_master_chk_i (
    .clock(clock),
    .reset(reset),
    .ss(ss),
    .sclk(sclk),
    .data_valid(data_valid),
    .ss_polarity(ss_polarity),
    .clock_polarity(clock_polarity)
);

/* test/spi_master_tb.sv */
/*
 * Testbench for the multi-lane SPI master
 * Each lane's MISO is fed from the next lane's MOSI, and directed tests run over the bus
 */
module spi_master_tb;

    // The slow divider test needs about 1200 cycles, all tests together far less than this
    localparam int timeout_cycles = 20000;

    logic clock;
    logic reset;
    logic bus_write;
    logic bus_read;
    logic [spi_regs_pkg::bus_addr_width-1:0] bus_address;
    logic [spi_regs_pkg::bus_data_width-1:0] bus_write_data;
    logic start;
    logic [spi_core_pkg::n_channels-1:0] miso;
    logic [spi_regs_pkg::bus_data_width-1:0] bus_read_data;
    logic [spi_core_pkg::n_channels-1:0] mosi;
    logic sclk;
    logic ss;
    logic data_valid;
    logic [spi_core_pkg::word_width-1:0] data_out [spi_core_pkg::n_channels];

    // Words last written to the data registers, one per lane
    logic [31:0] sent_words [spi_core_pkg::n_channels];
    int seed = 32'h4673;
    int cycle_count = 0;
    int valid_count = 0;

    // MOSI lanes and cycle number at each SCLK transition of the current transfer
    logic [spi_core_pkg::n_channels-1:0] serial_bits [$];
    int edge_cycles [$];
    logic last_sclk;

    spi_master spi_master_i (
        .clock(clock),
        .reset(reset),
        .bus_write(bus_write),
        .bus_read(bus_read),
        .bus_address(bus_address),
        .bus_write_data(bus_write_data),
        .start(start),
        .miso(miso),
        .bus_read_data(bus_read_data),
        .mosi(mosi),
        .sclk(sclk),
        .ss(ss),
        .data_valid(data_valid),
        .data_out(data_out)
    );

    // Lane i receives what lane i+1 sends, so a swapped lane shows up as wrong data
    for (genvar i = 0; i < spi_core_pkg::n_channels; i++) begin : g_loop
        assign miso[i] = mosi[(i + 1) % spi_core_pkg::n_channels];
    end

    always #10 clock = ~clock;

    always @(posedge clock) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= timeout_cycles) begin
            $display("Timeout: the run did not finish within %0d clock cycles", cycle_count);
            $display("*** TEST FAILED ***");
            $fatal(1, "Simulation stopped by the cycle limit");
        end
    end

    // Counts done pulses, sampled at the edge where they are stable
    always @(posedge clock) begin
        if (data_valid) begin
            valid_count <= valid_count + 1;
        end
    end

    // Every SCLK transition records MOSI, so leading edges land on the even entries
    always @(posedge clock) begin
        last_sclk <= sclk;
        if (sclk !== last_sclk) begin
            serial_bits.push_back(mosi);
            edge_cycles.push_back(cycle_count);
        end
    end

    task automatic check_value(input string test_name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (expected !== actual) begin
            $display("CHECK FAILED %s: expected %h, actual %h", test_name, expected, actual);
            $display("*** TEST FAILED ***");
            $fatal(1, "Value mismatch");
        end
    endtask

    // A write takes effect on the edge after the strobe is driven
    task automatic bus_write_reg(input logic [5:0] address, input logic [31:0] data);
        @(posedge clock);
        bus_write <= 1'b1;
        bus_address <= address;
        bus_write_data <= data;
        @(posedge clock);
        bus_write <= 1'b0;
    endtask

    // Read data is registered on the edge that sees the strobe, taken at the next negedge
    task automatic bus_read_reg(input logic [5:0] address, output logic [31:0] data);
        @(posedge clock);
        bus_read <= 1'b1;
        bus_address <= address;
        @(posedge clock);
        bus_read <= 1'b0;
        @(negedge clock);
        data = bus_read_data;
    endtask

    // Control word built from the register field positions
    function automatic logic [31:0] make_control(input int divider, input int bits,
                                                 input logic lsb, input logic ss_pol,
                                                 input logic clk_pol);
        logic [31:0] word;
        int length_code;
        word = '0;
        length_code = bits - 1;
        word[spi_regs_pkg::ctl_divider_lsb +: spi_regs_pkg::ctl_divider_width] = divider[2:0];
        word[spi_regs_pkg::ctl_length_lsb +: spi_regs_pkg::ctl_length_width] = length_code[4:0];
        word[spi_regs_pkg::ctl_lsb_first_bit] = lsb;
        word[spi_regs_pkg::ctl_ss_polarity_bit] = ss_pol;
        word[spi_regs_pkg::ctl_clock_polarity_bit] = clk_pol;
        return word;
    endfunction

    task automatic load_tx_words();
        for (int i = 0; i < spi_core_pkg::n_channels; i++) begin
            sent_words[i] = $random(seed);
            bus_write_reg(6'(spi_regs_pkg::addr_data_0 + 4 * i), sent_words[i]);
        end
        // SCLK is idle here, so the next transition is the first leading edge
        serial_bits.delete();
        edge_cycles.delete();
    endtask

    task automatic wait_data_valid();
        @(negedge clock);
        while (!data_valid) begin
            @(negedge clock);
        end
    endtask

    // Lane i must hold the low bits of the word sent by lane i+1, upper bits zero
    task automatic check_lanes(input string test_name, input int bits);
        logic [31:0] mask;
        mask = (bits >= 32) ? 32'hFFFF_FFFF : ((32'd1 << bits) - 32'd1);
        for (int i = 0; i < spi_core_pkg::n_channels; i++) begin
            check_value(test_name,
                        sent_words[(i + 1) % spi_core_pkg::n_channels] & mask, data_out[i]);
        end
    endtask

    // Two SCLK transitions per bit, each a half period of 2 * (divider + 1) cycles apart
    // MSB first puts bit n-1 out first, LSB first puts bit 0 out first
    task automatic check_serial(input string test_name, input int bits, input logic lsb,
                                input int divider);
        int position;
        check_value({test_name, " edges"}, 32'(2 * bits), 32'(serial_bits.size()));
        for (int k = 1; k < 2 * bits; k++) begin
            check_value({test_name, " half period"}, 32'(2 * (divider + 1)),
                        32'(edge_cycles[k] - edge_cycles[k - 1]));
        end
        for (int k = 0; k < bits; k++) begin
            position = lsb ? k : bits - 1 - k;
            for (int i = 0; i < spi_core_pkg::n_channels; i++) begin
                check_value({test_name, " mosi"}, 32'(sent_words[i][position]),
                            32'(serial_bits[2 * k][i]));
            end
        end
    endtask

    task automatic test_reset();
        logic [31:0] word;
        @(negedge clock);
        check_value("reset ss", 32'd1, 32'(ss));
        check_value("reset sclk", 32'd0, 32'(sclk));
        for (int i = 0; i < spi_core_pkg::n_channels; i++) begin
            check_value("reset data_out", 32'd0, data_out[i]);
        end
        bus_read_reg(spi_regs_pkg::addr_control, word);
        check_value("reset control", 32'd0, word);
        bus_read_reg(spi_regs_pkg::addr_status, word);
        check_value("reset status", 32'd0, word);
    endtask

    task automatic test_full_msb();
        logic [31:0] word;
        bus_write_reg(spi_regs_pkg::addr_control, make_control(0, 32, 1'b0, 1'b0, 1'b0));
        load_tx_words();
        bus_write_reg(spi_regs_pkg::addr_trigger, 32'h0);
        wait_data_valid();
        check_lanes("full_msb", 32);
        check_serial("full_msb", 32, 1'b0, 0);
        // The data registers read back the received words
        for (int i = 0; i < spi_core_pkg::n_channels; i++) begin
            bus_read_reg(6'(spi_regs_pkg::addr_data_0 + 4 * i), word);
            check_value("full_msb readback", sent_words[(i + 1) % spi_core_pkg::n_channels], word);
        end
    endtask

    task automatic test_short_lsb();
        int lengths [3] = '{1, 8, 17};
        for (int k = 0; k < 3; k++) begin
            bus_write_reg(spi_regs_pkg::addr_control,
                          make_control(0, lengths[k], 1'b1, 1'b0, 1'b0));
            load_tx_words();
            bus_write_reg(spi_regs_pkg::addr_trigger, 32'h5);
            wait_data_valid();
            check_lanes("short_lsb", lengths[k]);
            check_serial("short_lsb", lengths[k], 1'b1, 0);
        end
    endtask

    task automatic test_polarity();
        bus_write_reg(spi_regs_pkg::addr_control, make_control(1, 20, 1'b0, 1'b1, 1'b1));
        @(negedge clock);
        // Active high SS rests low, SCLK idles high
        check_value("polarity idle ss", 32'd0, 32'(ss));
        check_value("polarity idle sclk", 32'd1, 32'(sclk));
        load_tx_words();
        bus_write_reg(spi_regs_pkg::addr_trigger, 32'h0);
        wait_data_valid();
        check_lanes("polarity", 20);
        check_serial("polarity", 20, 1'b0, 1);
        check_value("polarity end ss", 32'd0, 32'(ss));
        check_value("polarity end sclk", 32'd1, 32'(sclk));
    endtask

    task automatic test_divider_start();
        logic [31:0] word;
        int count_before;
        bus_write_reg(spi_regs_pkg::addr_control, make_control(3, 32, 1'b0, 1'b0, 1'b0));
        load_tx_words();
        count_before = valid_count;
        @(posedge clock);
        start <= 1'b1;
        @(posedge clock);
        start <= 1'b0;
        bus_read_reg(spi_regs_pkg::addr_status, word);
        check_value("divider_start busy", 32'd1, word);
        // Trigger while busy must be dropped, not queued
        bus_write_reg(spi_regs_pkg::addr_trigger, 32'h0);
        wait_data_valid();
        check_lanes("divider_start", 32);
        check_serial("divider_start", 32, 1'b0, 3);
        bus_read_reg(spi_regs_pkg::addr_status, word);
        check_value("divider_start idle", 32'd0, word);
        // Longer than a whole transfer at this divider, so a queued start would show
        repeat (600) @(posedge clock);
        @(negedge clock);
        check_value("divider_start pulses", 32'(count_before + 1), 32'(valid_count));
    endtask

    initial begin
        clock = 1'b0;
        reset = 1'b0;
        bus_write = 1'b0;
        bus_read = 1'b0;
        bus_address = '0;
        bus_write_data = '0;
        start = 1'b0;
        repeat (5) @(posedge clock);
        reset <= 1'b1;
        test_reset();
        test_full_msb();
        test_short_lsb();
        test_polarity();
        test_divider_start();
        $display("*** TEST PASSED ***");
        $finish;
    end

endmodule

/* compile.f */
logic/spi_regs_pkg.sv
logic/spi_core_pkg.sv
logic/spi_sclk_gen.sv
logic/spi_reg_decode.sv
logic/spi_transfer_engine.sv
logic/spi_shift_channel.sv
logic/spi_master.sv
test/spi_master_chk.sv
test/spi_master_tb.sv

/* Makefile */
VERILATOR = verilator
VFLAGS = --binary --timing --assert -j 0
TOP = spi_master_tb
FILELIST = compile.f
OBJ_DIR = obj_dir
PASS_TEXT = *** TEST PASSED ***

# Build, run, and succeed only if the pass message appears
simulate:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee /dev/stderr | grep -q -F "$(PASS_TEXT)"

clean:
	rm -rf $(OBJ_DIR)
